// File: Makefile
TOP  := tb_csr_spi
SRCS := audio_csr_pkg.sv spi_trx.sv csr.sv csr_spi.sv tb_csr_spi.sv

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/V$(TOP): sim.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sim.f

# exit status of the simulator is the test result
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: audio_csr_pkg.sv
package audio_csr_pkg;

    localparam int NUM_CH       = 8;
    localparam int NUM_SPDIF_IN = 3;
    localparam int NUM_RATE     = 5;

    localparam int VOL_WIDTH   = 32 * NUM_CH;
    localparam int RATE_WIDTH  = NUM_SPDIF_IN * NUM_RATE;
    localparam int UDATA_WIDTH = 192 * NUM_SPDIF_IN;
    localparam int CDATA_WIDTH = 192 * NUM_SPDIF_IN;

    // bytes visible in each window
    localparam int VOL_BYTES   = VOL_WIDTH / 8;
    localparam int UDATA_BYTES = UDATA_WIDTH / 8;
    localparam int CDATA_BYTES = CDATA_WIDTH / 8;

    localparam logic [7:0] IDLE_REPLY = 8'hcc;

    // window select, upper nibble of the address
    localparam logic [3:0] WIN_VOL   = 4'd0;
    localparam logic [3:0] WIN_RATE  = 4'd8;
    localparam logic [3:0] WIN_UDATA = 4'd9;
    localparam logic [3:0] WIN_CDATA = 4'd10;

    typedef struct packed {
        logic [3:0] ch;
        logic [7:0] low;
    } csr_addr_t;

    // command byte layout, msb first
    typedef struct packed {
        logic [1:0] nrep_code;
        logic       we;
        logic       target_csr;
        logic [3:0] ch;
    } csr_cmd_t;

    typedef struct packed {
        csr_addr_t  addr;
        logic [7:0] data;
        logic       en;
    } csr_wr_t;

    // burst carries decode_nrep + 1 data bytes
    function automatic logic [7:0] decode_nrep(input logic [1:0] code);
        logic [7:0] n;
        case (code)
            2'd0:    n = 8'd0;
            2'd1:    n = 8'd3;
            2'd2:    n = 8'd63;
            default: n = 8'd255;
        endcase
        return n;
    endfunction

endpackage

// File: csr.sv
`timescale 1ns/1ps

module csr (
    input  logic                                   clk,
    input  logic                                   rst,
    input  audio_csr_pkg::csr_wr_t                 wr_i,
    input  audio_csr_pkg::csr_addr_t               rd_addr_i,
    output logic [7:0]                             rd_data_o,
    output logic [audio_csr_pkg::VOL_WIDTH-1:0]    vol_o,
    input  logic [audio_csr_pkg::RATE_WIDTH-1:0]   rate_i,
    input  logic [audio_csr_pkg::UDATA_WIDTH-1:0]  udata_i,
    input  logic [audio_csr_pkg::CDATA_WIDTH-1:0]  cdata_i
);

    import audio_csr_pkg::*;

    localparam int VOL_AW = $clog2(VOL_BYTES);

    logic [VOL_WIDTH-1:0] vol_q;   // byte n at bits 8n+7:8n
    logic                 wr_hit;
    logic [VOL_AW-1:0]    wr_idx;

    assign wr_hit = wr_i.en
                 && wr_i.addr.ch == WIN_VOL
                 && int'(wr_i.addr.low) < VOL_BYTES;
    assign wr_idx = wr_i.addr.low[VOL_AW-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            vol_q <= '0;
        end else if (wr_hit) begin
            vol_q[8*wr_idx +: 8] <= wr_i.data;
        end
    end

    assign vol_o = vol_q;

    // read mux, out-of-window bytes read as zero
    always_comb begin
        int unsigned idx;
        idx       = int'(rd_addr_i.low);
        rd_data_o = 8'h00;
        case (rd_addr_i.ch)
            WIN_VOL: begin
                if (idx < VOL_BYTES) begin
                    rd_data_o = vol_q[8*idx +: 8];
                end
            end
            WIN_RATE: begin
                if (idx < NUM_SPDIF_IN) begin
                    rd_data_o = 8'(rate_i[NUM_RATE*idx +: NUM_RATE]);  // zero-extended
                end
            end
            WIN_UDATA: begin
                if (idx < UDATA_BYTES) begin
                    rd_data_o = udata_i[8*idx +: 8];
                end
            end
            WIN_CDATA: begin
                if (idx < CDATA_BYTES) begin
                    rd_data_o = cdata_i[8*idx +: 8];
                end
            end
            default: rd_data_o = 8'h00;
        endcase
    end

    // read-only windows never reach the volume store
    a_ro_write_ignored: assert property (
        @(posedge clk) disable iff (rst)
        (wr_i.en && wr_i.addr.ch != WIN_VOL) |=> $stable(vol_o)
    );

endmodule

// File: csr_spi.sv
`timescale 1ns/1ps

module csr_spi (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   sck_i,
    input  logic                                   mosi_i,
    input  logic                                   ss_i,
    output logic                                   miso_o,
    output logic [audio_csr_pkg::VOL_WIDTH-1:0]    vol_o,
    input  logic [audio_csr_pkg::RATE_WIDTH-1:0]   rate_i,
    input  logic [audio_csr_pkg::UDATA_WIDTH-1:0]  udata_i,
    input  logic [audio_csr_pkg::CDATA_WIDTH-1:0]  cdata_i
);

    import audio_csr_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PEND_ADDR,
        ST_PEND_DATA,
        ST_RESPOND
    } state_t;

    state_t     state_q;

    logic [7:0] rx_data;
    logic       rx_pop;
    logic       frame_end;
    logic [7:0] tx_data_q;

    csr_cmd_t   cmd;
    logic [7:0] nrep_q;       // data bytes left after the current one
    logic       we_q;
    logic [3:0] ch_q;
    logic [7:0] addr_low_q;

    csr_addr_t  cur_addr;
    csr_wr_t    wr;
    logic [7:0] rd_data;

    spi_trx trx_i (
        .clk         (clk),
        .rst         (rst),
        .sck_i       (sck_i),
        .mosi_i      (mosi_i),
        .ss_i        (ss_i),
        .miso_o      (miso_o),
        .rx_data_o   (rx_data),
        .rx_pop_o    (rx_pop),
        .frame_end_o (frame_end),
        .tx_data_i   (tx_data_q)
    );

    assign cmd = csr_cmd_t'(rx_data);

    assign cur_addr.ch  = ch_q;
    assign cur_addr.low = addr_low_q;

    // write lands in the pop cycle, readback sees it one cycle later
    assign wr.addr = cur_addr;
    assign wr.data = rx_data;
    assign wr.en   = (state_q == ST_PEND_DATA) && rx_pop && we_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= ST_IDLE;
            tx_data_q <= 8'h00;
            nrep_q    <= '0;
            we_q      <= 1'b0;
        end else if (frame_end) begin
            state_q <= ST_IDLE;   // ss high aborts any burst
        end else begin
            case (state_q)
                ST_IDLE: begin
                    tx_data_q <= IDLE_REPLY;
                    // exchange commands are dropped here
                    if (rx_pop && cmd.target_csr) begin
                        nrep_q  <= decode_nrep(cmd.nrep_code);
                        we_q    <= cmd.we;
                        state_q <= ST_PEND_ADDR;
                    end
                end
                ST_PEND_ADDR: begin
                    if (rx_pop) begin
                        state_q <= ST_PEND_DATA;
                    end
                end
                ST_PEND_DATA: begin
                    if (rx_pop) begin
                        state_q <= ST_RESPOND;
                    end
                end
                ST_RESPOND: begin
                    tx_data_q <= rd_data;   // goes out during the next byte
                    nrep_q    <= nrep_q - 8'd1;
                    if (nrep_q == 8'd0) begin
                        state_q <= ST_IDLE;
                    end else begin
                        state_q <= ST_PEND_DATA;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // address payload
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && rx_pop) begin
            ch_q <= cmd.ch;
        end
        if (state_q == ST_PEND_ADDR && rx_pop) begin
            addr_low_q <= rx_data;
        end else if (state_q == ST_RESPOND) begin
            addr_low_q <= addr_low_q + 8'd1;   // wraps, channel nibble kept
        end
    end

    csr csr_i (
        .clk       (clk),
        .rst       (rst),
        .wr_i      (wr),
        .rd_addr_i (cur_addr),
        .rd_data_o (rd_data),
        .vol_o     (vol_o),
        .rate_i    (rate_i),
        .udata_i   (udata_i),
        .cdata_i   (cdata_i)
    );

    // after a respond step the count has been used up or is below its start,
    // so waiting for data with 8'hff left means the counter wrapped
    a_nrep_no_underflow: assert property (
        @(posedge clk) disable iff (rst)
        (state_q == ST_RESPOND) |=> (state_q != ST_PEND_DATA || nrep_q != 8'hff)
    );

endmodule

// File: sim.f
audio_csr_pkg.sv
spi_trx.sv
csr.sv
csr_spi.sv
tb_csr_spi.sv

// File: spi_trx.sv
`timescale 1ns/1ps

module spi_trx (
    input  logic       clk,
    input  logic       rst,
    input  logic       sck_i,
    input  logic       mosi_i,
    input  logic       ss_i,
    output logic       miso_o,
    output logic [7:0] rx_data_o,
    output logic       rx_pop_o,
    output logic       frame_end_o,
    input  logic [7:0] tx_data_i
);

    // [0],[1] synchronizer stages, [2] history for edge detect
    logic [2:0] sck_sync;
    logic [2:0] ss_sync;
    logic [1:0] mosi_sync;

    logic       sck_rise;
    logic       sck_fall;
    logic       ss_rise;
    logic       ss_fall;
    logic       ss_high;

    logic [2:0] bit_cnt;
    logic [6:0] rx_shift;
    logic [7:0] tx_shift;
    logic [1:0] pop_dly;

    always_ff @(posedge clk) begin
        if (rst) begin
            sck_sync  <= '0;
            ss_sync   <= '1;   // idle frame, no spurious ss edge
            mosi_sync <= '0;
        end else begin
            sck_sync  <= {sck_sync[1:0], sck_i};
            ss_sync   <= {ss_sync[1:0], ss_i};
            mosi_sync <= {mosi_sync[0], mosi_i};
        end
    end

    assign ss_high  = ss_sync[1];
    assign sck_rise = sck_sync[1] & ~sck_sync[2];
    assign sck_fall = ~sck_sync[1] & sck_sync[2];
    assign ss_rise  = ss_sync[1] & ~ss_sync[2];
    assign ss_fall  = ~ss_sync[1] & ss_sync[2];

    assign frame_end_o = ss_rise;

    // receive side, bit counter held at 0 outside a frame
    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt  <= '0;
            rx_pop_o <= 1'b0;
        end else begin
            rx_pop_o <= 1'b0;
            if (ss_high) begin
                bit_cnt <= '0;
            end else if (sck_rise) begin
                bit_cnt  <= bit_cnt + 3'd1;
                rx_pop_o <= (bit_cnt == 3'd7);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!ss_high && sck_rise) begin
            rx_shift <= {rx_shift[5:0], mosi_sync[1]};
            if (bit_cnt == 3'd7) begin
                rx_data_o <= {rx_shift, mosi_sync[1]};
            end
        end
    end

    // transmit side
    // the falling edge after the 8th rise is skipped (bit_cnt back at 0),
    // so the byte loaded after rx_pop keeps its msb on miso
    always_ff @(posedge clk) begin
        if (rst) begin
            pop_dly  <= '0;
            tx_shift <= '0;
        end else begin
            pop_dly <= {pop_dly[0], rx_pop_o};
            if (ss_fall || pop_dly[1]) begin
                tx_shift <= tx_data_i;
            end else if (sck_fall && !ss_high && bit_cnt != 3'd0) begin
                tx_shift <= {tx_shift[6:0], 1'b0};
            end
        end
    end

    assign miso_o = tx_shift[7];

    // a byte only completes inside a frame
    a_pop_in_frame: assert property (
        @(posedge clk) disable iff (rst)
        rx_pop_o |-> !ss_high
    );

endmodule

// File: tb_csr_spi.sv
`timescale 1ns/1ps

module tb_csr_spi;

    import audio_csr_pkg::*;

    localparam int HALF_CYCLES = 6;    // sck phase in clk cycles
    localparam int GAP_CYCLES  = 10;   // idle time between bytes
    localparam int SS_SETUP    = 10;
    localparam int SS_HOLD     = 12;

    // one byte is 8 bits of two sck phases plus edge alignment, then the gap
    localparam int BYTE_CYCLES    = 8 * (2 * HALF_CYCLES + 2) + GAP_CYCLES + 1;
    localparam int TEST_BYTES     = 540;   // ~500 bytes sent, frame overhead on top
    localparam int TIMEOUT_CYCLES = 3 * TEST_BYTES * BYTE_CYCLES;

    logic                   clk;
    logic                   rst;
    logic                   sck;
    logic                   mosi;
    logic                   ss;
    logic                   miso;
    logic [VOL_WIDTH-1:0]   vol;
    logic [RATE_WIDTH-1:0]  rate_bus;
    logic [UDATA_WIDTH-1:0] udata_bus;
    logic [CDATA_WIDTH-1:0] cdata_bus;

    logic [31:0] lfsr_q = 32'hef24;
    logic [7:0]  vol_model [VOL_BYTES];

    logic [7:0] tx_q  [$];   // bytes of the next frame
    logic [7:0] rx_q  [$];   // miso bytes as collected
    logic [7:0] exp_q [$];   // predicted replies, same order

    logic [7:0] reply_got;
    logic [7:0] reply_want;
    int         reply_cnt = 0;
    int         cycle_cnt = 0;

    csr_spi dut_i (
        .clk     (clk),
        .rst     (rst),
        .sck_i   (sck),
        .mosi_i  (mosi),
        .ss_i    (ss),
        .miso_o  (miso),
        .vol_o   (vol),
        .rate_i  (rate_bus),
        .udata_i (udata_bus),
        .cdata_i (cdata_bus)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_fail();
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] want, input string what);
        if (got !== want) begin
            $display("[FAIL] %0t: %s got %02h expected %02h", $time, what, got, want);
            stop_fail();
        end
    endtask

    task automatic check_vol(input logic [VOL_WIDTH-1:0] got, input logic [VOL_WIDTH-1:0] want);
        if (got !== want) begin
            $display("[FAIL] %0t: vol_o mismatch\n  got      %h\n  expected %h",
                     $time, got, want);
            stop_fail();
        end
    endtask

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0000_0000);
    endfunction

    task automatic rand_byte(output logic [7:0] v);
        for (int i = 0; i < 8; i++) begin
            v      = {v[6:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    function automatic logic [VOL_WIDTH-1:0] vol_expected();
        logic [VOL_WIDTH-1:0] v;
        for (int n = VOL_BYTES - 1; n >= 0; n--) begin
            v = {v[VOL_WIDTH-9:0], vol_model[5'(n)]};
        end
        return v;
    endfunction

    // only the first 32 bytes of window 0 are writable
    task automatic model_write(input csr_addr_t a, input logic [7:0] d);
        if (a.ch == WIN_VOL && int'(a.low) < VOL_BYTES) begin
            vol_model[a.low[4:0]] = d;
        end
    endtask

    function automatic logic [7:0] predict_reply(input csr_addr_t a);
        int         n;
        logic [7:0] r;
        n = int'(a.low);
        r = 8'h00;
        if (a.ch == WIN_VOL && n < VOL_BYTES) begin
            r = vol_model[a.low[4:0]];
        end else if (a.ch == WIN_RATE && n < NUM_SPDIF_IN) begin
            r = {3'b000, rate_bus[NUM_RATE*n +: NUM_RATE]};   // 5 flags per input
        end else if (a.ch == WIN_UDATA && n < UDATA_BYTES) begin
            r = udata_bus[8*n +: 8];
        end else if (a.ch == WIN_CDATA && n < CDATA_BYTES) begin
            r = cdata_bus[8*n +: 8];
        end
        return r;
    endfunction

    // mode 0, msb first; miso read just before each rising sck
    task automatic xfer_byte(input logic [7:0] tx);
        logic [7:0] sh;
        logic [7:0] rx;
        sh = tx;
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            mosi <= sh[7];
            sh = {sh[6:0], 1'b0};
            repeat (HALF_CYCLES) @(posedge clk);
            @(negedge clk);
            rx = {rx[6:0], miso};
            @(posedge clk);
            sck <= 1'b1;
            repeat (HALF_CYCLES) @(posedge clk);
            sck <= 1'b0;
        end
        @(negedge clk);
        rx_q.push_back(rx);
        repeat (GAP_CYCLES) @(posedge clk);
    endtask

    task automatic spi_frame();
        @(posedge clk);
        ss <= 1'b0;
        repeat (SS_SETUP) @(posedge clk);
        foreach (tx_q[i]) begin
            xfer_byte(tx_q[i]);
        end
        @(posedge clk);
        ss <= 1'b1;
        repeat (SS_HOLD) @(posedge clk);
    endtask

    // command, low address, n_data data bytes, optional dummy byte to fetch the last reply
    task automatic reg_burst(input logic [1:0] code, input logic we, input logic [3:0] ch,
                             input logic [7:0] low, input int n_data, input bit trailing);
        csr_cmd_t   cmd;
        csr_addr_t  a;
        logic [7:0] d;
        logic [7:0] prev;
        @(negedge clk);
        cmd.nrep_code  = code;
        cmd.we         = we;
        cmd.target_csr = 1'b1;
        cmd.ch         = ch;
        tx_q.delete();
        tx_q.push_back(cmd);
        tx_q.push_back(low);
        exp_q.push_back(IDLE_REPLY);
        exp_q.push_back(IDLE_REPLY);
        prev = IDLE_REPLY;   // nothing read back yet during data byte 0
        for (int k = 0; k < n_data; k++) begin
            rand_byte(d);
            a.ch  = ch;
            a.low = low + 8'(k);   // low byte wraps, nibble stays
            tx_q.push_back(d);
            exp_q.push_back(prev);
            if (we) begin
                model_write(a, d);
            end
            prev = predict_reply(a);
        end
        if (trailing) begin
            tx_q.push_back(8'h00);   // target_csr clear, ignored
            exp_q.push_back(prev);
        end
        spi_frame();
    endtask

    task automatic vol_matches();
        @(negedge clk);
        check_vol(vol, vol_expected());
    endtask

    always @(posedge clk) begin
        if (rx_q.size() != 0) begin
            if (exp_q.size() == 0) begin
                $display("a reply byte arrived with no expected value queued");
                stop_fail();
            end else begin
                reply_got  = rx_q.pop_front();
                reply_want = exp_q.pop_front();
                check_byte(reply_got, reply_want, $sformatf("reply byte %0d", reply_cnt));
                reply_cnt++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_fail();
        end
    end

    initial begin
        rst  <= 1'b1;
        sck  <= 1'b0;
        mosi <= 1'b0;
        ss   <= 1'b1;
        for (int i = 0; i < RATE_WIDTH; i++) begin
            rate_bus = {rate_bus[RATE_WIDTH-2:0], lfsr_q[0]};
            lfsr_q   = lfsr_next(lfsr_q);
        end
        for (int i = 0; i < UDATA_WIDTH; i++) begin
            udata_bus = {udata_bus[UDATA_WIDTH-2:0], lfsr_q[0]};
            lfsr_q    = lfsr_next(lfsr_q);
        end
        for (int i = 0; i < CDATA_WIDTH; i++) begin
            cdata_bus = {cdata_bus[CDATA_WIDTH-2:0], lfsr_q[0]};
            lfsr_q    = lfsr_next(lfsr_q);
        end
        for (int n = 0; n < VOL_BYTES; n++) begin
            vol_model[5'(n)] = 8'h00;
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        // miso quiet before any frame
        repeat (20) begin
            @(negedge clk);
            check_byte({7'd0, miso}, 8'h00, "miso after reset");
        end
        vol_matches();

        reg_burst(2'd1, 1'b1, WIN_VOL, 8'd4, 4, 1'b1);
        vol_matches();

        reg_burst(2'd2, 1'b0, WIN_VOL, 8'd0, 64, 1'b1);
        vol_matches();

        // read-only windows, reads run past the end of each
        reg_burst(2'd1, 1'b0, WIN_RATE, 8'd0, 4, 1'b1);
        reg_burst(2'd2, 1'b0, WIN_UDATA, 8'd30, 64, 1'b1);
        reg_burst(2'd2, 1'b0, WIN_CDATA, 8'd40, 64, 1'b1);
        reg_burst(2'd1, 1'b1, WIN_RATE, 8'd0, 4, 1'b1);
        reg_burst(2'd1, 1'b1, WIN_UDATA, 8'd70, 4, 1'b1);
        vol_matches();

        // 256 bytes from 200, wraps through 255 to 0
        reg_burst(2'd3, 1'b1, WIN_VOL, 8'd200, 256, 1'b1);
        vol_matches();

        // ss rises after 3 of 64 data bytes
        reg_burst(2'd2, 1'b1, WIN_VOL, 8'd8, 3, 1'b0);
        vol_matches();
        reg_burst(2'd0, 1'b0, WIN_VOL, 8'd8, 1, 1'b1);

        // every byte has target_csr clear
        @(negedge clk);
        tx_q.delete();
        tx_q.push_back(8'he0);   // we set, would aim at volume byte 5 if decoded
        tx_q.push_back(8'h05);
        tx_q.push_back(8'h2a);
        tx_q.push_back(8'h00);
        repeat (4) exp_q.push_back(IDLE_REPLY);
        spi_frame();
        vol_matches();

        repeat (4) @(posedge clk);
        if (exp_q.size() != 0 || rx_q.size() != 0) begin
            $display("reply count mismatch: %0d expected and %0d received bytes left over",
                     exp_q.size(), rx_q.size());
            stop_fail();
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule
